// File: design/soc_cfg.svh
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// rom depth as log2 of 32-bit words
`define SOC_ROM_BITS 8

// ram depth as log2 of 32-bit words
`define SOC_RAM_BITS 8

// timer width so it wraps every 2**bits cycles
`define SOC_TIMER_BITS 10

// lowest bit of the region selector
`define SOC_SEL_BIT 30

`endif

// File: design/soc_bus_pkg.sv
`include "soc_cfg.svh"

package soc_bus_pkg;

    // region from the top address bits
    typedef enum logic [31-`SOC_SEL_BIT:0] {
        REGION_ROM      = 0,
        REGION_RAM      = 1,
        REGION_UNMAPPED = 2,
        REGION_PORTS    = 3
    } region_t;

    // same word seen as a plain address or as decode fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            region_t                 region;
            logic [`SOC_SEL_BIT-3:0] word;
            logic [1:0]              offset;
        } f;
    } bus_addr_t;

    localparam logic MASTER_CORE   = 1'b0;
    localparam logic MASTER_LOADER = 1'b1;

endpackage

// File: design/soc_periph_pkg.sv
package soc_periph_pkg;

    // read layout of the port word from bit 6 down to bit 0
    typedef struct packed {
        logic con;
        logic psh;
        logic tra;
        logic trb;
        logic bak;
        logic scl;
        logic sda;
    } port_in_t;

    // written bits 2:0 where a drive of 1 releases the line
    typedef struct packed {
        logic led;
        logic scl_drive;
        logic sda_drive;
    } port_out_t;

    localparam int TIMER_IRQ = 3;

endpackage

// File: design/bus_arbiter.sv
`timescale 1ns/1ns

module bus_arbiter (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        core_valid,
    input  logic [31:0] core_addr,
    input  logic [31:0] core_wdata,
    input  logic [3:0]  core_wstrb,
    input  logic        ldr_valid,
    input  logic [31:0] ldr_addr,
    input  logic [31:0] ldr_wdata,
    input  logic [3:0]  ldr_wstrb,
    input  logic        done,
    input  logic [31:0] rdata,
    output logic        core_ready,
    output logic [31:0] core_rdata,
    output logic        ldr_ready,
    output logic [31:0] ldr_rdata,
    output logic        bus_valid,
    output logic [31:0] bus_addr,
    output logic [31:0] bus_wdata,
    output logic [3:0]  bus_wstrb,
    output logic        bus_from_loader
);

    logic busy;
    logic grant;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            grant     <= soc_bus_pkg::MASTER_CORE;
            bus_valid <= 1'b0;
        end else if (!busy) begin
            // loader wins a tie
            if (ldr_valid) begin
                busy      <= 1'b1;
                grant     <= soc_bus_pkg::MASTER_LOADER;
                bus_valid <= 1'b1;
            end else if (core_valid) begin
                busy      <= 1'b1;
                grant     <= soc_bus_pkg::MASTER_CORE;
                bus_valid <= 1'b1;
            end
        end else begin
            bus_valid <= 1'b0;
            // hold grant until the router finishes
            if (done) begin
                busy <= 1'b0;
            end
        end
    end

    // request latch onto the shared bus
    always_ff @(posedge clk) begin
        if (!busy) begin
            bus_addr  <= ldr_valid ? ldr_addr  : core_addr;
            bus_wdata <= ldr_valid ? ldr_wdata : core_wdata;
            bus_wstrb <= ldr_valid ? ldr_wstrb : core_wstrb;
        end
    end

    assign bus_from_loader = (grant == soc_bus_pkg::MASTER_LOADER);

    assign ldr_ready  = busy && done && (grant == soc_bus_pkg::MASTER_LOADER);
    assign core_ready = busy && done && (grant == soc_bus_pkg::MASTER_CORE);
    assign ldr_rdata  = (grant == soc_bus_pkg::MASTER_LOADER) ? rdata : 32'h0;
    assign core_rdata = (grant == soc_bus_pkg::MASTER_CORE) ? rdata : 32'h0;

endmodule

// File: design/addr_router.sv
`timescale 1ns/1ns

module addr_router (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  bus_valid,
    input  soc_bus_pkg::bus_addr_t bus_addr,
    input  logic [3:0]            bus_wstrb,
    input  logic                  bus_from_loader,
    input  logic [31:0]           rom_rdata,
    input  logic [31:0]           ram_rdata,
    input  logic [31:0]           port_rdata,
    output logic                  rom_sel,
    output logic [3:0]            rom_wstrb,
    output logic                  ram_sel,
    output logic                  port_sel,
    output logic                  done,
    output logic [31:0]           rdata,
    output logic                  fault
);

    logic rom_q;
    logic ram_q;
    logic port_q;
    logic unmap_q;
    logic unmap_sel;

    assign rom_sel   = bus_valid && (bus_addr.f.region == soc_bus_pkg::REGION_ROM);
    assign ram_sel   = bus_valid && (bus_addr.f.region == soc_bus_pkg::REGION_RAM);
    assign port_sel  = bus_valid && (bus_addr.f.region == soc_bus_pkg::REGION_PORTS);
    assign unmap_sel = bus_valid && (bus_addr.f.region == soc_bus_pkg::REGION_UNMAPPED);

    // rom is write protected against the core
    assign rom_wstrb = bus_from_loader ? bus_wstrb : 4'b0000;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rom_q   <= 1'b0;
            ram_q   <= 1'b0;
            port_q  <= 1'b0;
            unmap_q <= 1'b0;
            done    <= 1'b0;
            fault   <= 1'b0;
        end else begin
            rom_q   <= rom_sel;
            ram_q   <= ram_sel;
            port_q  <= port_sel;
            unmap_q <= unmap_sel;
            done    <= rom_q || ram_q || port_q || unmap_q;
            fault   <= unmap_q;
        end
    end

    // targets answer one cycle after the select
    always_ff @(posedge clk) begin
        if (rom_q)       rdata <= rom_rdata;
        else if (ram_q)  rdata <= ram_rdata;
        else if (port_q) rdata <= port_rdata;
        else             rdata <= 32'h0;
    end

endmodule

// File: design/mem_banks.sv
`timescale 1ns/1ns

`include "soc_cfg.svh"

module mem_banks (
    input  logic                   clk,
    input  logic                   rom_sel,
    input  logic [3:0]             rom_wstrb,
    input  logic                   ram_sel,
    input  logic [3:0]             ram_wstrb,
    input  soc_bus_pkg::bus_addr_t addr,
    input  logic [31:0]            wdata,
    output logic [31:0]            rom_rdata,
    output logic [31:0]            ram_rdata
);

    localparam int ROM_DEPTH = 1 << `SOC_ROM_BITS;
    localparam int RAM_DEPTH = 1 << `SOC_RAM_BITS;

    logic [31:0]               rom [0:ROM_DEPTH-1];
    logic [`SOC_ROM_BITS-1:0]  rom_idx;
    logic [`SOC_RAM_BITS-1:0]  ram_idx;

    // indexed by word with the byte offset ignored
    assign rom_idx = addr.f.word[`SOC_ROM_BITS-1:0];
    assign ram_idx = addr.f.word[`SOC_RAM_BITS-1:0];

    always_ff @(posedge clk) begin
        if (rom_sel) begin
            for (int b = 0; b < 4; b++) begin
                if (rom_wstrb[b]) begin
                    rom[rom_idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
            rom_rdata <= rom[rom_idx];
        end
    end

    // one byte array per lane
    for (genvar lane = 0; lane < 4; lane++) begin : g_lane
        logic [7:0] ram [0:RAM_DEPTH-1];
        logic [7:0] q;

        always_ff @(posedge clk) begin
            if (ram_sel) begin
                if (ram_wstrb[lane]) begin
                    ram[ram_idx] <= wdata[8*lane +: 8];
                end
                q <= ram[ram_idx];
            end
        end

        assign ram_rdata[8*lane +: 8] = q;
    end

endmodule

// File: design/io_ports.sv
`timescale 1ns/1ns

module io_ports (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        port_sel,
    input  logic [3:0]  wstrb,
    input  logic [31:0] wdata,
    input  logic        con_button,
    input  logic        psh_button,
    input  logic        tra,
    input  logic        trb,
    input  logic        bak_button,
    input  logic        scl_in,
    input  logic        sda_in,
    output logic [31:0] port_rdata,
    output logic        led,
    output logic        scl_drive,
    output logic        sda_drive
);

    soc_periph_pkg::port_in_t  in_q;
    soc_periph_pkg::port_out_t out_q;

    // pins sampled every cycle
    always_ff @(posedge clk) begin
        in_q <= {con_button, psh_button, tra, trb, bak_button, scl_in, sda_in};
        if (port_sel) begin
            port_rdata <= {25'b0, in_q};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // led on, both i2c lines released
            out_q <= 3'b111;
        end else if (port_sel && wstrb[0]) begin
            out_q <= wdata[2:0];
        end
    end

    assign led       = out_q.led;
    assign scl_drive = out_q.scl_drive;
    assign sda_drive = out_q.sda_drive;

endmodule

// File: design/irq_timer.sv
`timescale 1ns/1ns

`include "soc_cfg.svh"

module irq_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic eoi,
    output logic irq
);

    logic [`SOC_TIMER_BITS-1:0] count;
    logic                       wrap_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count  <= '0;
            wrap_q <= 1'b0;
            irq    <= 1'b0;
        end else begin
            count  <= count + 1'b1;
            // high for the cycle where count reads zero after a wrap
            wrap_q <= (count == {`SOC_TIMER_BITS{1'b1}});
            // a new wrap wins over eoi
            if (wrap_q) begin
                irq <= 1'b1;
            end else if (eoi) begin
                irq <= 1'b0;
            end
        end
    end

endmodule

// File: design/soc_fabric.sv
`timescale 1ns/1ns

module soc_fabric (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        core_valid,
    input  logic [31:0] core_addr,
    input  logic [31:0] core_wdata,
    input  logic [3:0]  core_wstrb,
    output logic        core_ready,
    output logic [31:0] core_rdata,
    input  logic        ldr_valid,
    input  logic [31:0] ldr_addr,
    input  logic [31:0] ldr_wdata,
    input  logic [3:0]  ldr_wstrb,
    output logic        ldr_ready,
    output logic [31:0] ldr_rdata,
    output logic [31:0] irq,
    input  logic [31:0] eoi,
    output logic        fault,
    input  logic        con_button,
    input  logic        psh_button,
    input  logic        tra,
    input  logic        trb,
    input  logic        bak_button,
    input  logic        scl_in,
    input  logic        sda_in,
    output logic        led,
    output logic        scl_drive,
    output logic        sda_drive
);

    logic        bus_valid;
    logic [31:0] bus_addr;
    logic [31:0] bus_wdata;
    logic [3:0]  bus_wstrb;
    logic        bus_from_loader;
    logic        done;
    logic [31:0] rdata;
    logic        rom_sel;
    logic [3:0]  rom_wstrb;
    logic        ram_sel;
    logic        port_sel;
    logic [31:0] rom_rdata;
    logic [31:0] ram_rdata;
    logic [31:0] port_rdata;
    logic        timer_irq;

    bus_arbiter i_bus_arbiter (
        .clk, .rst_n,
        .core_valid, .core_addr, .core_wdata, .core_wstrb,
        .ldr_valid, .ldr_addr, .ldr_wdata, .ldr_wstrb,
        .done, .rdata,
        .core_ready, .core_rdata, .ldr_ready, .ldr_rdata,
        .bus_valid, .bus_addr, .bus_wdata, .bus_wstrb, .bus_from_loader
    );

    addr_router i_addr_router (
        .clk, .rst_n,
        .bus_valid, .bus_addr, .bus_wstrb, .bus_from_loader,
        .rom_rdata, .ram_rdata, .port_rdata,
        .rom_sel, .rom_wstrb, .ram_sel, .port_sel,
        .done, .rdata, .fault
    );

    mem_banks i_mem_banks (
        .clk,
        .rom_sel, .rom_wstrb,
        .ram_sel, .ram_wstrb(bus_wstrb),
        .addr(bus_addr), .wdata(bus_wdata),
        .rom_rdata, .ram_rdata
    );

    io_ports i_io_ports (
        .clk, .rst_n,
        .port_sel, .wstrb(bus_wstrb), .wdata(bus_wdata),
        .con_button, .psh_button, .tra, .trb, .bak_button, .scl_in, .sda_in,
        .port_rdata, .led, .scl_drive, .sda_drive
    );

    irq_timer i_irq_timer (
        .clk, .rst_n,
        .eoi(eoi[soc_periph_pkg::TIMER_IRQ]),
        .irq(timer_irq)
    );

    // only the timer line is live
    assign irq = {31'b0, timer_irq} << soc_periph_pkg::TIMER_IRQ;

endmodule

// File: verif/soc_checker.sv
`timescale 1ns/1ns

`include "soc_cfg.svh"

module soc_checker (
    input logic        clk,
    input logic        rst_n,
    input logic        core_valid,
    input logic        core_ready,
    input logic [31:0] core_rdata,
    input logic        ldr_valid,
    input logic        ldr_ready,
    input logic [31:0] ldr_rdata,
    input logic        fault,
    input logic [31:0] irq,
    input logic        led,
    input logic        scl_drive,
    input logic        sda_drive
);

    int cycle;
    int core_start;
    int ldr_start;
    int ldr_done = -1;
    int irq_rise = -1;
    int tests = 0;
    int errors = 0;
    logic core_valid_q;
    logic ldr_valid_q;

    // expectations per master in issue order
    logic [31:0] exp_data [2][$];
    logic        exp_cmp [2][$];
    logic        exp_flt [2][$];
    int          exp_lat [2][$];

    always @(posedge clk) begin
        if (!rst_n) begin
            cycle        <= 0;
            core_valid_q <= 1'b0;
            ldr_valid_q  <= 1'b0;
        end else begin
            cycle        <= cycle + 1;
            core_valid_q <= core_valid;
            ldr_valid_q  <= ldr_valid;
            if (core_valid && !core_valid_q) begin
                core_start <= cycle;
            end
            if (ldr_valid && !ldr_valid_q) begin
                ldr_start <= cycle;
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n && irq[soc_periph_pkg::TIMER_IRQ] && irq_rise < 0) begin
            irq_rise = cycle;
        end
        // loader first so its finish time is known for the core
        if (rst_n && ldr_ready) begin
            finish_txn(1'b1, ldr_rdata, cycle - ldr_start);
            ldr_done = cycle;
        end
        if (rst_n && core_ready) begin
            finish_txn(1'b0, core_rdata, cycle - core_start);
        end
    end

    task automatic expect_txn(input logic from_ldr, input logic [31:0] data,
                              input logic cmp, input logic flt, input int lat);
        exp_data[from_ldr].push_back(data);
        exp_cmp[from_ldr].push_back(cmp);
        exp_flt[from_ldr].push_back(flt);
        exp_lat[from_ldr].push_back(lat);
    endtask

    task automatic finish_txn(input logic from_ldr, input logic [31:0] got, input int lat);
        string who;
        logic [31:0] data;
        logic cmp;
        logic flt;
        int want_lat;
        int bad;
        who = from_ldr ? "ldr" : "core";
        bad = 0;
        tests++;
        if (exp_data[from_ldr].size() == 0) begin
            $display("test %0d: %s gave a ready with no access pending", tests, who);
            errors++;
        end else begin
            data = exp_data[from_ldr].pop_front();
            cmp = exp_cmp[from_ldr].pop_front();
            flt = exp_flt[from_ldr].pop_front();
            want_lat = exp_lat[from_ldr].pop_front();
            if (cmp && got !== data) begin
                $display("Error: %s_rdata got %h expected %h", who, got, data);
                bad++;
            end
            if (fault !== flt) begin
                $display("Error: fault got %h expected %h", fault, flt);
                bad++;
            end
            if (want_lat > 0 && lat != want_lat) begin
                $display("Error: %s_ready latency got %h expected %h", who, lat, want_lat);
                bad++;
            end
            // a core access that lost arbitration must end after the loader
            if (!from_ldr && want_lat == 0 && ldr_done < core_start) begin
                $display("core access finished before the competing loader access");
                bad++;
            end
            errors += (bad > 0) ? 1 : 0;
            $display("test %0d: %s access %s", tests, who, (bad > 0) ? "failed" : "ok");
        end
    endtask

    task automatic check_pins(input logic [2:0] want);
        tests++;
        if ({led, scl_drive, sda_drive} !== want) begin
            $display("Error: led/scl_drive/sda_drive got %h expected %h",
                     {led, scl_drive, sda_drive}, want);
            errors++;
        end else begin
            $display("test %0d: port pins ok", tests);
        end
    endtask

    // only the timer line may ever be set
    task automatic check_irq(input logic want);
        logic [31:0] exp_irq;
        exp_irq = want ? (32'h1 << soc_periph_pkg::TIMER_IRQ) : 32'h0;
        tests++;
        if (irq !== exp_irq) begin
            $display("Error: irq got %h expected %h", irq, exp_irq);
            errors++;
        end else begin
            $display("test %0d: irq level ok", tests);
        end
    endtask

    task automatic check_irq_rise();
        tests++;
        if (irq_rise != (1 << `SOC_TIMER_BITS) + 1) begin
            $display("Error: irq rise cycle got %h expected %h",
                     irq_rise, (1 << `SOC_TIMER_BITS) + 1);
            errors++;
        end else begin
            $display("test %0d: irq rise time ok", tests);
        end
    endtask

endmodule

// File: verif/tb_soc_fabric.sv
`timescale 1ns/1ns

`include "soc_cfg.svh"

module tb_soc_fabric;

    logic        clk;
    logic        rst_n;
    logic        core_valid;
    logic [31:0] core_addr;
    logic [31:0] core_wdata;
    logic [3:0]  core_wstrb;
    logic        core_ready;
    logic [31:0] core_rdata;
    logic        ldr_valid;
    logic [31:0] ldr_addr;
    logic [31:0] ldr_wdata;
    logic [3:0]  ldr_wstrb;
    logic        ldr_ready;
    logic [31:0] ldr_rdata;
    logic [31:0] irq;
    logic [31:0] eoi;
    logic        fault;
    logic        con_button;
    logic        psh_button;
    logic        tra;
    logic        trb;
    logic        bak_button;
    logic        scl_in;
    logic        sda_in;
    logic        led;
    logic        scl_drive;
    logic        sda_drive;

    integer seed = 32'h7f57d1e3;
    int     limit;
    logic   loaded = 1'b0;

    // one entry per pattern line
    logic [7:0]  p_master [$];
    logic [7:0]  p_op [$];
    logic [31:0] p_addr [$];
    logic [31:0] p_wdata [$];
    logic [3:0]  p_strb [$];
    logic [31:0] p_exp [$];
    logic        p_fault [$];
    logic        p_conc [$];

    soc_fabric i_soc_fabric (.*);

    soc_checker i_checker (
        .clk, .rst_n, .core_valid, .core_ready, .core_rdata,
        .ldr_valid, .ldr_ready, .ldr_rdata, .fault, .irq,
        .led, .scl_drive, .sda_drive
    );

    always #50 clk = ~clk;

    task automatic load_patterns();
        int fd;
        int r;
        string line;
        logic [7:0] m;
        logic [7:0] op;
        logic [31:0] a;
        logic [31:0] w;
        logic [31:0] s;
        logic [31:0] e;
        logic [31:0] f;
        logic [31:0] c;
        fd = $fopen("verif/bus_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file verif/bus_patterns.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                r = $fgets(line, fd);
                if (line.len() > 2 && line[0] != "#") begin
                    r = $sscanf(line, "%c %c %h %h %h %h %h %h", m, op, a, w, s, e, f, c);
                    if (r == 8) begin
                        p_master.push_back(m);
                        p_op.push_back(op);
                        p_addr.push_back(a);
                        p_wdata.push_back(w);
                        p_strb.push_back(s[3:0]);
                        p_exp.push_back(e);
                        p_fault.push_back(f[0]);
                        p_conc.push_back(c[0]);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    function automatic logic master_of(input int i);
        return (p_master[i] == "l") ? soc_bus_pkg::MASTER_LOADER : soc_bus_pkg::MASTER_CORE;
    endfunction

    // random pins and the expected word from the port layout
    task automatic randomize_pins(output logic [31:0] want);
        soc_periph_pkg::port_in_t pins;
        pins = 7'($random(seed));
        @(negedge clk);
        con_button = pins.con;
        psh_button = pins.psh;
        tra = pins.tra;
        trb = pins.trb;
        bak_button = pins.bak;
        scl_in = pins.scl;
        sda_in = pins.sda;
        repeat (2) @(negedge clk);
        want = {25'b0, pins};
    endtask

    task automatic prepare_line(input int i);
        logic [31:0] want;
        logic cmp;
        want = p_exp[i];
        cmp = (p_op[i] == "r");
        if (p_op[i] == "p") begin
            randomize_pins(want);
            cmp = 1'b1;
        end
        // second line of a pair may have to wait for the bus
        i_checker.expect_txn(master_of(i), want, cmp, p_fault[i],
                             (i > 0 && p_conc[i-1]) ? 0 : 3);
    endtask

    task automatic run_line(input int i);
        @(negedge clk);
        if (master_of(i) == soc_bus_pkg::MASTER_LOADER) begin
            ldr_valid = 1'b1;
            ldr_addr = p_addr[i];
            ldr_wdata = p_wdata[i];
            ldr_wstrb = p_strb[i];
            do @(negedge clk); while (!ldr_ready);
            ldr_valid = 1'b0;
            ldr_wstrb = 4'h0;
        end else begin
            core_valid = 1'b1;
            core_addr = p_addr[i];
            core_wdata = p_wdata[i];
            core_wstrb = p_strb[i];
            do @(negedge clk); while (!core_ready);
            core_valid = 1'b0;
            core_wstrb = 4'h0;
        end
    endtask

    initial begin
        wait (loaded);
        repeat (limit) @(posedge clk);
        $display("the run timed out after %0d cycles without finishing", limit);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        int i;
        clk = 1'b0;
        rst_n = 1'b0;
        core_valid = 1'b0;
        core_addr = 32'h0;
        core_wdata = 32'h0;
        core_wstrb = 4'h0;
        ldr_valid = 1'b0;
        ldr_addr = 32'h0;
        ldr_wdata = 32'h0;
        ldr_wstrb = 4'h0;
        eoi = 32'h0;
        con_button = 1'b0;
        psh_button = 1'b0;
        tra = 1'b0;
        trb = 1'b0;
        bak_button = 1'b0;
        scl_in = 1'b0;
        sda_in = 1'b0;
        load_patterns();
        limit = p_addr.size() * 20 + 2 * (1 << `SOC_TIMER_BITS) + 10;
        loaded = 1'b1;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        // led on and both i2c lines released after reset
        i_checker.check_pins(3'b111);

        i = 0;
        while (i < p_addr.size()) begin
            if (p_conc[i] && i + 1 < p_addr.size()) begin
                prepare_line(i);
                prepare_line(i + 1);
                fork
                    run_line(i);
                    run_line(i + 1);
                join
                i += 2;
            end else begin
                prepare_line(i);
                run_line(i);
                if (p_op[i] == "o") begin
                    i_checker.check_pins(p_exp[i][2:0]);
                end
                i += 1;
            end
        end

        // timer interrupt and then end-of-interrupt on line 3
        wait (irq[soc_periph_pkg::TIMER_IRQ]);
        repeat (5) @(negedge clk);
        i_checker.check_irq_rise();
        i_checker.check_irq(1'b1);
        eoi[soc_periph_pkg::TIMER_IRQ] = 1'b1;
        @(negedge clk);
        eoi = 32'h0;
        i_checker.check_irq(1'b0);

        @(negedge clk);
        $display("tests run: %0d, failed: %0d", i_checker.tests, i_checker.errors);
        if (i_checker.errors == 0 && p_addr.size() > 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: soc_fabric.f
+incdir+design
design/soc_bus_pkg.sv
design/soc_periph_pkg.sv
design/bus_arbiter.sv
design/addr_router.sv
design/mem_banks.sv
design/io_ports.sv
design/irq_timer.sv
design/soc_fabric.sv
verif/soc_checker.sv
verif/tb_soc_fabric.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the soc_fabric testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f soc_fabric.f --top-module tb_soc_fabric -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^=== PASS ===$" sim.log; then
    exit 0
fi
exit 1

// File: verif/bus_patterns.txt
# master(l/c) op(w write, r read, p port read, o port write) addr wdata wstrb exp fault conc
# conc 1 launches the line together with the next one
l w 00000000 13579bdf f 00000000 0 0
l w 00000004 2468ace0 f 00000000 0 0
l w 40000000 cafef00d f 00000000 0 0
l w 40000010 11223344 f 00000000 0 0
c r 00000000 00000000 0 13579bdf 0 0
c r 00000004 00000000 0 2468ace0 0 0
c r 40000000 00000000 0 cafef00d 0 0
c w 40000010 aabbccdd 5 00000000 0 0
c r 40000010 00000000 0 11bb33dd 0 0
c w 00000004 deadbeef f 00000000 0 0
c r 00000004 00000000 0 2468ace0 0 0
c r 80000000 00000000 0 00000000 1 0
l r 80000004 00000000 0 00000000 1 0
l w 40000020 0badc0de f 00000000 0 1
c r 40000000 00000000 0 cafef00d 0 0
l r 40000020 00000000 0 0badc0de 0 1
c r 00000000 00000000 0 13579bdf 0 0
c o c0000000 00000002 1 00000002 0 0
c p c0000000 00000000 0 00000000 0 0
l o c0000000 00000005 1 00000005 0 0
l p c0000000 00000000 0 00000000 0 0
